//--- Makefile
# Verilator build and run for the softusb_phy testbench.
VERILATOR ?= verilator
TOP       ?= softusb_phy_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= files.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+include
src/usb_line_pkg.sv
src/usb_data_pkg.sv
src/softusb_filter.sv
src/softusb_tx.sv
src/softusb_rx.sv
src/softusb_phy.sv
tests/softusb_phy_asserts.sv
tests/softusb_phy_tb.sv

//--- include/usb_phy_params.svh
// USB PHY timing parameters.
// Sets bit lengths per speed, stuffing limit, synchronizer depth and EOP shape.
`ifndef USB_PHY_PARAMS_SVH
`define USB_PHY_PARAMS_SVH

// usb_clk cycles per full-speed bit.
`define USB_FS_BIT_CLKS 4
// usb_clk cycles per low-speed bit.
`define USB_LS_BIT_CLKS 32

// run of ones that forces a stuffed zero.
`define USB_STUFF_LIMIT 6

// flops between pad and line state.
`define USB_SYNC_STAGES 2

// se0 bit times before the closing j.
`define USB_EOP_SE0_BITS 2

`endif

//--- src/softusb_filter.sv
// USB pad input synchronizer.
// Brings one port's sampled pins into usb_clk and reports the line state.
`timescale 1ns/1ps
`default_nettype none
`include "usb_phy_params.svh"

module softusb_filter (
	input  logic                      usb_clk,
	input  usb_line_pkg::pad_sample_t pins,
	output usb_line_pkg::line_state_t line,
	output logic                      rcv
);
	import usb_line_pkg::*;

	localparam int LAST = `USB_SYNC_STAGES - 1; // index of the output stage.

	pad_sample_t sync_q [`USB_SYNC_STAGES]; // metastability chain.

	always_ff @(posedge usb_clk) begin
		sync_q[0] <= pins; // first stage may go metastable.
		for (int i = 1; i < `USB_SYNC_STAGES; i++) begin
			sync_q[i] <= sync_q[i-1]; // settle through the chain.
		end
	end

	assign rcv  = sync_q[LAST].rcv;                     // differential bit.
	assign line = {sync_q[LAST].vm, sync_q[LAST].vp}; // single-ended state.

endmodule

`default_nettype wire

//--- src/softusb_phy.sv
// Two-port USB 1.1 line interface.
// Synchronizes both ports, steers receive and transmit, drives bus reset.
`timescale 1ns/1ps
`default_nettype none
`include "usb_phy_params.svh"

module softusb_phy (
	input  logic                      usb_clk,
	input  logic                      usb_rst,

	input  usb_line_pkg::pad_sample_t usba_pins,
	output usb_line_pkg::pad_drive_t  usba_drive,
	output logic                      usba_spd,     // high for full speed.
	input  usb_line_pkg::pad_sample_t usbb_pins,
	output usb_line_pkg::pad_drive_t  usbb_drive,
	output logic                      usbb_spd,

	output usb_line_pkg::line_state_t line_state_a,
	output usb_line_pkg::line_state_t line_state_b,

	input  logic                      port_sel_rx,  // 0 is port a.
	input  logic [1:0]                port_sel_tx,  // transmit enable per port.
	input  logic [1:0]                generate_reset, // force se0 per port.
	input  logic                      tx_low_speed,
	input  logic [1:0]                low_speed,    // speed per port.
	input  logic                      generate_eop,

	input  usb_data_pkg::usb_byte_t   tx_data,
	input  logic                      tx_valid,
	output logic                      tx_ready,
	output logic                      tx_busy,      // packet or eop in flight.

	output usb_data_pkg::usb_byte_t   rx_data,
	output usb_data_pkg::rx_status_t  rx_status
);
	import usb_line_pkg::*;

	logic                        rcv_a;
	logic                        rcv_b;
	logic                        txp;
	logic                        txm;
	logic                        txoe;
	logic                        txoe_q;   // previous oe, for the falling edge.
	logic [`USB_SYNC_STAGES-1:0] oe_dly;   // oe aligned to the pad echo.
	logic                        rxreset;
	line_state_t                 line_sel;
	pad_drive_t                  drive [2];

	softusb_filter filter_a (
		.usb_clk (usb_clk),
		.pins    (usba_pins),
		.line    (line_state_a),
		.rcv     (rcv_a)
	);

	softusb_filter filter_b (
		.usb_clk (usb_clk),
		.pins    (usbb_pins),
		.line    (line_state_b),
		.rcv     (rcv_b)
	);

	softusb_tx tx (
		.usb_clk      (usb_clk),
		.usb_rst      (usb_rst),
		.tx_data      (tx_data),
		.tx_valid     (tx_valid),
		.tx_ready     (tx_ready),
		.low_speed    (tx_low_speed),
		.generate_eop (generate_eop),
		.txp          (txp),
		.txm          (txm),
		.txoe         (txoe)
	);

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txoe_q  <= 1'b0;
			oe_dly  <= '0;
			tx_busy <= 1'b0;
		end else begin
			txoe_q <= txoe;
			oe_dly <= {oe_dly[`USB_SYNC_STAGES-2:0], txoe}; // match filter latency.
			if (txoe_q && !txoe) begin
				tx_busy <= 1'b0; // one cycle after oe drops.
			end
			if (generate_eop || tx_valid) begin
				tx_busy <= 1'b1; // new request wins.
			end
		end
	end

	// our own echo must not look like a packet.
	assign rxreset  = usb_rst | oe_dly[`USB_SYNC_STAGES-1];
	assign line_sel = port_sel_rx ? line_state_b : line_state_a;

	softusb_rx rx (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rcv       (port_sel_rx ? rcv_b : rcv_a),
		.line      (line_sel),
		.low_speed (low_speed[port_sel_rx]),
		.rx_data   (rx_data),
		.rx_status (rx_status)
	);

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			drive[p].oe = (txoe & port_sel_tx[p]) | generate_reset[p];
			drive[p].vp = txp & ~generate_reset[p]; // bus reset is se0.
			drive[p].vm = txm & ~generate_reset[p];
		end
	end

	assign usba_drive = drive[0];
	assign usbb_drive = drive[1];
	assign usba_spd   = ~low_speed[0];
	assign usbb_spd   = ~low_speed[1];

endmodule

`default_nettype wire

//--- src/softusb_rx.sv
// USB receive chain.
// Recovers bit timing, hunts SYNC, NRZI decodes, unstuffs and assembles bytes.
`timescale 1ns/1ps
`default_nettype none
`include "usb_phy_params.svh"

module softusb_rx (
	input  logic                      usb_clk,
	input  logic                      rxreset,   // held while we transmit.
	input  logic                      rcv,       // synchronized differential bit.
	input  usb_line_pkg::line_state_t line,
	input  logic                      low_speed,
	output usb_data_pkg::usb_byte_t   rx_data,
	output usb_data_pkg::rx_status_t  rx_status
);
	import usb_line_pkg::*;
	import usb_data_pkg::*;

	localparam int PW = $clog2(`USB_LS_BIT_CLKS);     // phase counter width.
	localparam int OW = $clog2(`USB_STUFF_LIMIT + 1); // ones counter width.
	localparam logic [PW-1:0] FS_LAST  = PW'(`USB_FS_BIT_CLKS - 1);
	localparam logic [PW-1:0] LS_LAST  = PW'(`USB_LS_BIT_CLKS - 1);
	localparam logic [OW-1:0] STUFF_AT = OW'(`USB_STUFF_LIMIT);

	logic [PW-1:0] phase;     // clocks since the last edge or bit start.
	logic [PW-1:0] bit_last;  // bit length minus one.
	logic          rcv_q;     // previous rcv, for edge detect.
	logic          edge_seen;
	logic          sample;    // mid-bit strobe.
	logic          se0;
	logic          last_rcv;  // level of the previous bit.
	logic          bit_val;   // nrzi decoded bit.
	usb_byte_t     sr;        // sync hunt and deserializer.
	usb_byte_t     sr_next;
	logic [2:0]    bit_cnt;   // kept bits in the current byte.
	logic [OW-1:0] ones_cnt;  // consecutive ones received.

	always_comb begin
		bit_last  = low_speed ? LS_LAST : FS_LAST;
		edge_seen = rcv ^ rcv_q;
		sample    = ~edge_seen & (phase == (bit_last >> 1)); // middle of the bit.
		se0       = (line == LINE_SE0);
		bit_val   = (rcv == last_rcv); // no transition reads as one.
		sr_next   = {bit_val, sr[7:1]}; // lsb first.
	end

	assign rx_data = sr; // stable long after each strobe.

	always_ff @(posedge usb_clk) begin
		rcv_q <= rcv;
	end

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			phase     <= '0;
			last_rcv  <= rcv;
			sr        <= '1;
			bit_cnt   <= '0;
			ones_cnt  <= '0;
			rx_status <= '0;
		end else begin
			// resync on every edge, free-run between them.
			if (edge_seen || (phase == bit_last)) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
			rx_status.valid <= 1'b0;
			rx_status.error <= 1'b0;
			if (sample) begin
				if (se0) begin
					rx_status.active <= 1'b0; // eop, back to hunting.
					sr               <= '1;
				end else begin
					last_rcv <= rcv;
					if (!rx_status.active) begin
						sr <= sr_next;
						if (sr_next == USB_SYNC_BYTE) begin
							rx_status.active <= 1'b1;
							bit_cnt          <= '0;
							ones_cnt         <= OW'(1); // sync ends in a one.
						end
					end else if (ones_cnt == STUFF_AT) begin
						ones_cnt <= '0; // stuffed bit, dropped.
						if (bit_val) begin
							rx_status.error  <= 1'b1; // seventh one.
							rx_status.active <= 1'b0;
							sr               <= '1;
						end
					end else begin
						sr       <= sr_next;
						ones_cnt <= bit_val ? ones_cnt + 1'b1 : '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							rx_status.valid <= 1'b1; // eighth kept bit.
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/softusb_tx.sv
// USB transmit chain.
// Serializes bytes lsb first, stuffs, NRZI encodes and closes with SE0 SE0 J.
`timescale 1ns/1ps
`default_nettype none
`include "usb_phy_params.svh"

module softusb_tx (
	input  logic                    usb_clk,
	input  logic                    usb_rst,
	input  usb_data_pkg::usb_byte_t tx_data,
	input  logic                    tx_valid,
	output logic                    tx_ready,    // pulses when the byte is taken.
	input  logic                    low_speed,
	input  logic                    generate_eop, // lone eop request.
	output logic                    txp,
	output logic                    txm,
	output logic                    txoe
);
	import usb_data_pkg::*;

	localparam int TW = $clog2(`USB_LS_BIT_CLKS);      // bit timer width.
	localparam int OW = $clog2(`USB_STUFF_LIMIT + 1);  // ones counter width.
	localparam int EW = $clog2(`USB_EOP_SE0_BITS + 1); // se0 counter width.
	localparam logic [TW-1:0] FS_RELOAD = TW'(`USB_FS_BIT_CLKS - 1);
	localparam logic [TW-1:0] LS_RELOAD = TW'(`USB_LS_BIT_CLKS - 1);
	localparam logic [OW-1:0] STUFF_AT  = OW'(`USB_STUFF_LIMIT);
	localparam logic [EW-1:0] SE0_LAST  = EW'(`USB_EOP_SE0_BITS);

	typedef enum logic [1:0] {TX_IDLE, TX_DATA, TX_EOP, TX_JBIT} tx_state_t;

	tx_state_t     state;
	logic [TW-1:0] timer;      // clocks left in the current bit.
	logic [TW-1:0] reload;     // bit length minus one.
	logic          ls_q;       // speed latched at packet start.
	logic          level;      // nrzi level, 1 is j.
	logic          se0;        // drive both lines low.
	logic [OW-1:0] ones_cnt;   // consecutive ones sent.
	logic [EW-1:0] eop_cnt;    // se0 bits sent so far.
	logic [3:0]    bits_taken; // data bits used from sr.
	usb_byte_t     sr;         // serializer shift register.
	logic          emit;       // a new bit time starts now.
	logic          stuff;      // next bit is a stuffed zero.
	logic          byte_done;
	logic          send;       // next bit is a data bit.
	logic          eop_go;     // next bit opens the eop.
	logic          data_bit;

	always_comb begin
		emit      = (state == TX_IDLE) ? (tx_valid | generate_eop) : (timer == '0);
		stuff     = (state == TX_DATA) && (ones_cnt == STUFF_AT);
		byte_done = (bits_taken == 4'd8);
		// fetch at idle or at a byte boundary, never in place of a stuffed bit.
		tx_ready  = emit & tx_valid &
			((state == TX_IDLE) | ((state == TX_DATA) & ~stuff & byte_done));
		send      = tx_ready | (emit & (state == TX_DATA) & ~stuff & ~byte_done);
		eop_go    = emit & ~tx_ready &
			(((state == TX_IDLE) & generate_eop) | ((state == TX_DATA) & ~stuff & byte_done));
		data_bit  = tx_ready ? tx_data[0] : sr[0]; // bit 0 goes out with the load.
		reload    = ((state == TX_IDLE) ? low_speed : ls_q) ? LS_RELOAD : FS_RELOAD;
	end

	// j is vp high at full speed, vm high at low speed.
	assign txp = ~se0 & (level ^ ls_q);
	assign txm = ~se0 & ~(level ^ ls_q);

	always_ff @(posedge usb_clk) begin
		if (tx_ready) begin
			sr <= {1'b0, tx_data[7:1]}; // bit 0 already on the line.
		end else if (send) begin
			sr <= {1'b0, sr[7:1]};
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state      <= TX_IDLE;
			timer      <= '0;
			ls_q       <= 1'b0;
			level      <= 1'b1;
			se0        <= 1'b0;
			txoe       <= 1'b0;
			ones_cnt   <= '0;
			eop_cnt    <= '0;
			bits_taken <= '0;
		end else begin
			if (emit) begin
				timer <= reload; // restart bit timer.
			end else if (state != TX_IDLE) begin
				timer <= timer - 1'b1;
			end
			if ((state == TX_IDLE) && emit) begin
				ls_q <= low_speed; // speed fixed for the whole packet.
			end
			if (tx_ready) begin
				state      <= TX_DATA;
				txoe       <= 1'b1;
				bits_taken <= 4'd1;
			end else if (send) begin
				bits_taken <= bits_taken + 1'b1;
			end
			if (send) begin
				if (data_bit) begin
					ones_cnt <= ones_cnt + 1'b1; // one keeps the level.
				end else begin
					level    <= ~level; // zero toggles.
					ones_cnt <= '0;
				end
			end else if (emit && stuff) begin
				level    <= ~level; // stuffed zero, sr untouched.
				ones_cnt <= '0;
			end
			if (eop_go) begin
				state    <= TX_EOP;
				txoe     <= 1'b1;
				se0      <= 1'b1;
				eop_cnt  <= EW'(1);
				ones_cnt <= '0;
			end
			if (emit && (state == TX_EOP)) begin
				if (eop_cnt == SE0_LAST) begin
					state <= TX_JBIT;
					se0   <= 1'b0;
					level <= 1'b1; // closing j, also the idle level.
				end else begin
					eop_cnt <= eop_cnt + 1'b1;
				end
			end
			if (emit && (state == TX_JBIT)) begin
				state <= TX_IDLE;
				txoe  <= 1'b0; // release after the j bit.
			end
		end
	end

endmodule

`default_nettype wire

//--- src/usb_data_pkg.sv
// USB byte traffic types.
// Describes the bytes and receive status passed between PHY and controller.
`default_nettype none

package usb_data_pkg;

	typedef logic [7:0] usb_byte_t; // one data byte, sent lsb first.

	// sync as it lands in an lsb-first shift register.
	localparam usb_byte_t USB_SYNC_BYTE = 8'h80;

	// receive side report, one bundle per cycle.
	typedef struct packed {
		logic valid;  // one-cycle byte strobe.
		logic active; // sync seen, no eop yet.
		logic error;  // stuff error, pulses as active falls.
	} rx_status_t;

endpackage

`default_nettype wire

//--- src/usb_line_pkg.sv
// USB line types.
// Describes the sampled and driven pins of one port and the decoded line state.
`default_nettype none

package usb_line_pkg;

	// single-ended line state, {vm, vp}.
	typedef logic [1:0] line_state_t;

	localparam line_state_t LINE_SE0 = 2'b00; // both lines low.

	// what the transceiver hands us from one port.
	typedef struct packed {
		logic rcv; // differential receiver output.
		logic vp;  // single-ended plus line.
		logic vm;  // single-ended minus line.
	} pad_sample_t;

	// what we drive onto one port.
	typedef struct packed {
		logic oe; // output enable, high drives the bus.
		logic vp; // plus line level.
		logic vm; // minus line level.
	} pad_drive_t;

endpackage

`default_nettype wire

//--- tests/softusb_phy_asserts.sv
// USB PHY protocol assertions.
// Bound into softusb_phy to watch the handshakes and pad drive.
`timescale 1ns/1ps
`default_nettype none

module softusb_phy_asserts (
	input logic                     usb_clk,
	input logic                     usb_rst,
	input logic                     tx_valid,
	input logic                     tx_ready,
	input logic                     tx_busy,
	input usb_data_pkg::rx_status_t rx_status,
	input usb_line_pkg::pad_drive_t usba_drive,
	input usb_line_pkg::pad_drive_t usbb_drive,
	input logic [1:0]               port_sel_tx,
	input logic [1:0]               generate_reset
);
	import usb_line_pkg::*;
	import usb_data_pkg::*;

	ready_needs_valid: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |-> tx_valid ##1 !tx_ready)
		else $error("tx_ready not a single-cycle pulse under tx_valid");

	strobe_needs_active: assert property (@(posedge usb_clk) disable iff (usb_rst)
		rx_status.valid |-> rx_status.active) else $error("rx byte strobe outside a packet");

	// transmit drive only while a packet or eop is in flight.
	oe_a_allowed: assert property (@(posedge usb_clk) disable iff (usb_rst)
		usba_drive.oe |-> (generate_reset[0] | (port_sel_tx[0] & tx_busy)))
		else $error("port a driven while not selected or not busy");

	oe_b_allowed: assert property (@(posedge usb_clk) disable iff (usb_rst)
		usbb_drive.oe |-> (generate_reset[1] | (port_sel_tx[1] & tx_busy)))
		else $error("port b driven while not selected or not busy");

endmodule

`default_nettype wire

//--- tests/softusb_phy_tb.sv
// USB PHY testbench.
// Random packets through both directions, with line models for encode and decode.
`timescale 1ns/1ps
`default_nettype none
`include "usb_phy_params.svh"

module softusb_phy_tb;
	import usb_line_pkg::*;
	import usb_data_pkg::*;

	localparam int FS    = `USB_FS_BIT_CLKS;
	localparam int LS    = `USB_LS_BIT_CLKS;
	localparam int NPKT  = 4;                       // packets per speed and direction.
	localparam int LIMIT = (4 * NPKT + 8) * 100 * LS; // about 100 bit times per packet.

	logic        usb_clk;
	logic        usb_rst;
	pad_sample_t usba_pins;
	pad_sample_t usbb_pins;
	pad_drive_t  usba_drive;
	pad_drive_t  usbb_drive;
	logic        usba_spd;
	logic        usbb_spd;
	line_state_t line_state_a;
	line_state_t line_state_b;
	logic        port_sel_rx;
	logic [1:0]  port_sel_tx;
	logic [1:0]  generate_reset;
	logic        tx_low_speed;
	logic [1:0]  low_speed;
	logic        generate_eop;
	usb_byte_t   tx_data;
	logic        tx_valid;
	logic        tx_ready;
	logic        tx_busy;
	usb_byte_t   rx_data;
	rx_status_t  rx_status;

	logic [15:0] lfsr_q;     // stimulus generator state.
	int          cycles;
	int          ready_cnt;  // tx_ready pulses so far.
	int          active_cnt; // cycles with rx active.
	int          error_cnt;  // stuff error pulses.
	logic        m_busy;     // expected tx_busy.
	logic        oe_prev;
	logic        oe_now;
	line_state_t pins_a_q [2]; // port a {vm, vp} seen one and two cycles ago.
	line_state_t pins_b_q [2];
	logic        enc_lvl;    // encoder nrzi level, 1 is j.
	int          enc_ones;
	usb_byte_t   sent_q[$];
	usb_byte_t   got_q[$];
	usb_byte_t   rx_got[$];  // every strobed rx byte.

	softusb_phy softusb_phy_i (.*);

	bind softusb_phy softusb_phy_asserts asserts_i (.*);

	initial begin
		usb_clk = 1'b0;
		forever #4 usb_clk = ~usb_clk; // 8 ns period.
	end

	always @(posedge usb_clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout, the run did not finish in %0d cycles", LIMIT);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "mismatch");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "failure");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[6:0], lfsr_bit()}; // one step per bit.
		return r;
	endfunction

	function automatic pad_drive_t get_drive(input logic port);
		return port ? usbb_drive : usba_drive;
	endfunction

	function automatic logic is_j(input pad_drive_t d, input logic ls);
		return ls ? (d.vm & ~d.vp) : (d.vp & ~d.vm); // polarity swaps at low speed.
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge usb_clk);
		#1;
	endtask

	// busy model, line state delay, ready count and rx capture, all on the falling edge.
	always @(negedge usb_clk) begin
		if (usb_rst !== 1'b0) begin
			m_busy      = 1'b0;
			oe_prev     = 1'b0;
			pins_a_q[1] = {usba_pins.vm, usba_pins.vp};
			pins_b_q[1] = {usbb_pins.vm, usbb_pins.vp};
		end else begin
			assert (tx_busy == m_busy) else report_mismatch("tx_busy differs from model");
			assert (line_state_a == pins_a_q[1])
				else report_mismatch("line_state_a is not port a pins two cycles late");
			assert (line_state_b == pins_b_q[1])
				else report_mismatch("line_state_b is not port b pins two cycles late");
			pins_a_q[1] = pins_a_q[0];
			pins_b_q[1] = pins_b_q[0];
			oe_now = |(port_sel_tx & ~generate_reset & {usbb_drive.oe, usba_drive.oe});
			if (tx_valid || generate_eop)
				m_busy = 1'b1;
			else if (oe_prev && !oe_now)
				m_busy = 1'b0;
			oe_prev = oe_now;
			if (!generate_reset[0] && !port_sel_tx[0])
				assert (!usba_drive.oe) else report_mismatch("port a oe while not selected");
			if (tx_ready)
				ready_cnt++;
			if (rx_status.active)
				active_cnt++;
			if (rx_status.error)
				error_cnt++;
			if (rx_status.valid)
				rx_got.push_back(rx_data);
		end
		pins_a_q[0] = {usba_pins.vm, usba_pins.vp};
		pins_b_q[0] = {usbb_pins.vm, usbb_pins.vp};
	end

	task automatic send_bytes();
		foreach (sent_q[i]) begin
			@(posedge usb_clk);
			#1;
			tx_data  = sent_q[i];
			tx_valid = 1'b1;
			@(negedge usb_clk);
			while (!tx_ready)
				@(negedge usb_clk); // held until taken.
		end
		@(posedge usb_clk);
		#1;
		tx_valid = 1'b0;
	endtask

	// samples mid-bit, nrzi decodes, unstuffs, then checks se0 se0 j.
	task automatic decode_packet(input logic port, input logic ls);
		int         n;
		int         ones;
		int         nb;
		logic       prev;
		logic       lvl;
		logic       b;
		usb_byte_t  cur;
		pad_drive_t d;
		n    = ls ? LS : FS;
		ones = 0;
		nb   = 0;
		prev = 1'b1; // idle j.
		cur  = '0;
		got_q = {};
		@(negedge usb_clk);
		d = get_drive(port);
		while (!d.oe) begin
			@(negedge usb_clk);
			d = get_drive(port);
		end
		repeat (n / 2) @(negedge usb_clk);
		d = get_drive(port);
		while (d.vp || d.vm) begin
			assert (d.oe) else report_failure("oe dropped in the middle of a packet");
			lvl  = is_j(d, ls);
			b    = (lvl == prev);
			prev = lvl;
			if (ones == `USB_STUFF_LIMIT) begin
				assert (!b) else report_failure("more than six ones in a row on the line");
				ones = 0; // stuffed zero, dropped.
			end else begin
				ones = b ? ones + 1 : 0;
				cur  = {b, cur[7:1]};
				nb++;
				if (nb == 8) begin
					got_q.push_back(cur);
					nb = 0;
				end
			end
			repeat (n) @(negedge usb_clk);
			d = get_drive(port);
		end
		assert (nb == 0) else report_failure("packet did not end on a byte boundary");
		for (int i = 1; i < `USB_EOP_SE0_BITS; i++) begin
			repeat (n) @(negedge usb_clk);
			d = get_drive(port);
			assert (d.oe && !d.vp && !d.vm) else report_failure("EOP has too few SE0 bits");
		end
		repeat (n) @(negedge usb_clk);
		d = get_drive(port);
		assert (d.oe && is_j(d, ls)) else report_failure("EOP does not end with a J bit");
		repeat (n) @(negedge usb_clk);
		d = get_drive(port);
		assert (!d.oe) else report_failure("oe still high after the EOP");
	endtask

	task automatic run_tx(input logic port, input logic ls, input logic lone);
		int base;
		int nbytes;
		port_sel_tx  = port ? 2'b10 : 2'b01;
		tx_low_speed = ls;
		base   = ready_cnt;
		sent_q = {};
		nbytes = lone ? 0 : 1 + int'(rand_bits(3));
		for (int i = 0; i < nbytes; i++)
			sent_q.push_back(rand_bits(8));
		fork
			if (lone) begin
				wait_cycles(1);
				generate_eop = 1'b1;
				wait_cycles(1);
				generate_eop = 1'b0;
			end else begin
				send_bytes();
			end
			decode_packet(port, ls);
		join
		assert (got_q.size() == sent_q.size())
			else report_mismatch($sformatf("decoded %0d bytes, sent %0d", got_q.size(), nbytes));
		foreach (sent_q[i])
			assert (got_q[i] == sent_q[i])
				else report_mismatch($sformatf("byte %0d is %02h, sent %02h", i, got_q[i], sent_q[i]));
		assert (ready_cnt - base == nbytes) else report_mismatch("tx_ready count per packet");
		wait_cycles(4);
	endtask

	task automatic drive_level(input logic j, input logic se0, input logic ls);
		if (se0) begin
			usbb_pins.vp = 1'b0;
			usbb_pins.vm = 1'b0;
		end else begin
			usbb_pins.vp  = j ^ ls;
			usbb_pins.vm  = ~(j ^ ls);
			usbb_pins.rcv = j ^ ls;
		end
		wait_cycles(ls ? LS : FS);
	endtask

	task automatic encode_bit(input logic b, input logic ls, input logic stuff);
		if (!b)
			enc_lvl = ~enc_lvl; // zero toggles.
		enc_ones = b ? enc_ones + 1 : 0;
		drive_level(enc_lvl, 1'b0, ls);
		if (stuff && enc_ones == `USB_STUFF_LIMIT) begin
			enc_lvl  = ~enc_lvl;
			enc_ones = 0;
			drive_level(enc_lvl, 1'b0, ls);
		end
	endtask

	task automatic run_rx(input logic ls, input logic bad);
		int        base;
		int        act0;
		int        err0;
		int        nbytes;
		usb_byte_t exp_q[$];
		usb_byte_t v;
		base    = rx_got.size();
		act0    = active_cnt;
		err0    = error_cnt;
		enc_lvl = 1'b1;
		enc_ones = 0;
		assert (!rx_status.active) else report_failure("rx active before the packet");
		for (int i = 0; i < 8; i++)
			encode_bit(i == 7, ls, 1'b1); // sync kjkjkjkk.
		nbytes = bad ? 0 : 1 + int'(rand_bits(3));
		for (int i = 0; i < nbytes; i++) begin
			v = rand_bits(8);
			exp_q.push_back(v);
			for (int k = 0; k < 8; k++)
				encode_bit(v[k], ls, 1'b1);
		end
		if (bad)
			repeat (7) encode_bit(1'b1, ls, 1'b0); // no stuffing.
		repeat (`USB_EOP_SE0_BITS) drive_level(1'b0, 1'b1, ls);
		drive_level(1'b1, 1'b0, ls);
		enc_lvl = 1'b1;
		wait_cycles(4 * (ls ? LS : FS));
		assert (rx_got.size() - base == nbytes) else report_mismatch("rx byte count");
		foreach (exp_q[i])
			assert (rx_got[base + i] == exp_q[i])
				else report_mismatch($sformatf("rx byte %0d is %02h, expected %02h",
					i, rx_got[base + i], exp_q[i]));
		assert (active_cnt > act0) else report_failure("rx never went active");
		assert (!rx_status.active) else report_failure("rx still active after the EOP");
		if (bad)
			assert (error_cnt > err0) else report_failure("stuff error not reported");
	endtask

	initial begin
		usb_rst        = 1'b1;
		usba_pins      = '{rcv: 1'b1, vp: 1'b1, vm: 1'b0}; // full speed j.
		usbb_pins      = '{rcv: 1'b1, vp: 1'b1, vm: 1'b0};
		port_sel_rx    = 1'b0;
		port_sel_tx    = 2'b01;
		generate_reset = 2'b00;
		tx_low_speed   = 1'b0;
		low_speed      = 2'b00;
		generate_eop   = 1'b0;
		tx_data        = '0;
		tx_valid       = 1'b0;
		lfsr_q         = 16'd12630;
		cycles         = 0;
		ready_cnt      = 0;
		active_cnt     = 0;
		error_cnt      = 0;
		wait_cycles(2);
		usb_rst = 1'b0;
		wait_cycles(4);
		for (int sp = 0; sp < 2; sp++)
			for (int k = 0; k < NPKT; k++)
				run_tx(1'b0, sp[0], 1'b0);
		run_tx(1'b1, 1'b0, 1'b0); // port b, port a stays released.
		run_tx(1'b0, 1'b0, 1'b1); // lone eop.
		port_sel_rx = 1'b1;
		for (int sp = 0; sp < 2; sp++) begin
			low_speed = {sp[0], 1'b0};
			drive_level(1'b1, 1'b0, sp[0]);
			wait_cycles(10 * LS); // let the idle line settle.
			for (int k = 0; k < NPKT; k++)
				run_rx(sp[0], 1'b0);
			run_rx(sp[0], 1'b1);
		end
		port_sel_tx = 2'b00;
		for (int p = 0; p < 2; p++) begin
			generate_reset = 2'b01 << p;
			wait_cycles(1);
			assert (get_drive(p[0]).oe && !get_drive(p[0]).vp && !get_drive(p[0]).vm)
				else report_mismatch("bus reset is not SE0 on the chosen port");
			assert (!get_drive(~p[0]).oe) else report_mismatch("bus reset on the other port");
		end
		generate_reset = 2'b00;
		for (int v = 0; v < 4; v++) begin
			low_speed = 2'(v);
			wait_cycles(1);
			assert (usba_spd == !low_speed[0] && usbb_spd == !low_speed[1])
				else report_mismatch("spd does not follow low_speed");
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire
